/* design/dll_pkg.sv */
package dll_pkg;

   // Correlator magnitudes, unsigned
   localparam int IQ_WIDTH = 16;
   typedef logic [IQ_WIDTH-1:0] iq_t;

   // Channel tag that travels with each request
   localparam int CHANNEL_ID_WIDTH = 4;
   typedef logic [CHANNEL_ID_WIDTH-1:0] channel_id_t;

   // Sum and difference before truncation
   // One extra bit so early plus late cannot overflow
   localparam int OP_PRE_WIDTH = IQ_WIDTH + 1;
   typedef logic [OP_PRE_WIDTH-1:0] op_pre_t;

   // Bit position inside an op_pre_t
   localparam int OP_INDEX_WIDTH = 5;
   typedef logic [OP_INDEX_WIDTH-1:0] op_index_t;

   // Truncated operand width seen by the multiplier and divider
   localparam int OP_WIDTH = 10;
   typedef logic [OP_WIDTH-1:0] op_t;

   // Gain K, fixed point, scaled up by 2**SCALE_SHIFT
   localparam int SCALE_WIDTH = 16;
   localparam logic [SCALE_WIDTH-1:0] DLL_SCALE = 16'd51471;
   localparam int SCALE_SHIFT = 8;

   // Product of a truncated difference and K
   localparam int MULT_WIDTH = OP_WIDTH + SCALE_WIDTH;
   typedef logic [MULT_WIDTH-1:0] mult_t;

   // Signed phase-increment correction
   localparam int DPHI_WIDTH = 16;
   typedef logic signed [DPHI_WIDTH-1:0] dphi_t;

   // One restoring step per numerator bit
   localparam int DIV_STEPS = MULT_WIDTH;

   // Start cycle to result_ready pulse
   // 1 prep + 2 detect + 1 select + 1 load + DIV_STEPS divide
   localparam int DLL_LATENCY = 5 + DIV_STEPS;

   // Ratio core FSM
   typedef enum logic [1:0] {
      IDLE,
      LOAD,
      DIVIDE,
      DONE
   } core_state_t;

endpackage

/* design/dll_operand_prep.sv */
`timescale 1ns/1ps

module dll_operand_prep
   import dll_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        start,
   input  channel_id_t tag,
   input  iq_t         iq_early,
   input  iq_t         iq_late,
   output op_pre_t     sum_pre,
   output op_pre_t     diff_abs,
   output logic        diff_neg,
   output channel_id_t req_tag,
   output logic        op_valid
);

   // Counter wide enough to hold DLL_LATENCY
   typedef logic [$clog2(DLL_LATENCY+1)-1:0] lat_cnt_t;

   op_pre_t  early_ext;
   op_pre_t  late_ext;
   op_pre_t  sum_d;
   op_pre_t  diff_d;
   logic     late_gt;
   lat_cnt_t pend_cnt;
   logic     pending;
   logic     accept;

   // Zero-extend so the sum keeps its carry
   assign early_ext = op_pre_t'(iq_early);
   assign late_ext  = op_pre_t'(iq_late);

   assign sum_d   = early_ext + late_ext;
   assign late_gt = iq_late > iq_early;

   // Magnitude only, sign kept aside for the final result
   assign diff_d = late_gt ? late_ext - early_ext : early_ext - late_ext;

   // A request is in flight until its result has been presented
   assign pending = pend_cnt != '0;
   assign accept  = start && !pending;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pend_cnt <= '0;
         op_valid <= 1'b0;
      end else begin
         op_valid <= accept;
         if (accept) begin
            pend_cnt <= lat_cnt_t'(DLL_LATENCY);
         end else if (pending) begin
            pend_cnt <= pend_cnt - 1'b1;
         end
      end
   end

   // Operands stay put until the next accepted start
   // Detectors and ratio core read them over many cycles
   always_ff @(posedge clk) begin
      if (accept) begin
         sum_pre  <= sum_d;
         diff_abs <= diff_d;
         diff_neg <= late_gt;
         req_tag  <= tag;
      end
   end

   // No new start until the previous result has come out
   a_no_start_pending: assert property (
      @(posedge clk) disable iff (!rst_n)
      start |-> !pending
   );

endmodule

/* design/dll_lead_detect.sv */
`timescale 1ns/1ps

module dll_lead_detect
   import dll_pkg::*;
(
   input  logic      clk,
   input  logic      rst_n,
   input  op_pre_t   operand,
   input  logic      operand_valid,
   output op_index_t index,
   output logic      index_valid
);

   // Stage one results, per half
   logic      hi_found_d;
   op_index_t hi_pos_d;
   op_index_t lo_pos_d;

   logic      s1_valid;
   logic      hi_found;
   op_index_t hi_pos;
   op_index_t lo_pos;

   // Scan each half, last hit wins so the top set bit is kept
   always_comb begin
      hi_found_d = 1'b0;
      hi_pos_d   = '0;
      lo_pos_d   = '0;
      for (int i = 0; i < OP_PRE_WIDTH/2; i++) begin
         if (operand[i]) begin
            lo_pos_d = op_index_t'(i);
         end
      end
      for (int i = OP_PRE_WIDTH/2; i < OP_PRE_WIDTH; i++) begin
         if (operand[i]) begin
            hi_found_d = 1'b1;
            hi_pos_d   = op_index_t'(i);
         end
      end
   end

   // Valid strobes travel with the data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1_valid    <= 1'b0;
         index_valid <= 1'b0;
      end else begin
         s1_valid    <= operand_valid;
         index_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      // Stage one, partial positions per half
      if (operand_valid) begin
         hi_found <= hi_found_d;
         hi_pos   <= hi_pos_d;
         lo_pos   <= lo_pos_d;
      end
      // Stage two, upper half takes priority
      // Zero operand falls through to lo_pos, which is zero
      if (s1_valid) begin
         index <= hi_found ? hi_pos : lo_pos;
      end
   end

endmodule

/* design/dll_ratio_core.sv */
`timescale 1ns/1ps

module dll_ratio_core
   import dll_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  op_pre_t     sum_pre,
   input  op_pre_t     diff_abs,
   input  logic        diff_neg,
   input  channel_id_t req_tag,
   input  logic        op_valid,
   input  op_index_t   sum_index,
   input  op_index_t   diff_index,
   input  logic        index_valid,
   output logic        busy,
   output logic        result_ready,
   output channel_id_t result_tag,
   output dphi_t       delta_phase_increment
);

   // Step counter for the serial divider
   typedef logic [$clog2(DIV_STEPS)-1:0] step_t;

   core_state_t state;
   step_t       step;
   logic        busy_q;
   logic        last_step;

   // Truncation
   op_index_t   max_index;
   op_index_t   shamt;
   op_t         sum_trunc;
   op_t         diff_trunc;

   // Divider registers
   // quo starts as the numerator and shifts quotient bits in from the right
   op_t         den;
   op_t         rem;
   mult_t       quo;
   logic        neg_q;
   channel_id_t tag_q;

   // One restoring step
   logic [OP_WIDTH:0] trial;
   logic        fits;
   op_t         rem_next;
   mult_t       quo_next;
   mult_t       quo_final;
   dphi_t       mag;

   // Keep OP_WIDTH bits below the leading one of the larger operand
   // Small operands already fit and pass unshifted
   always_comb begin
      if (max_index >= op_index_t'(OP_WIDTH-1)) begin
         shamt = max_index - op_index_t'(OP_WIDTH-1);
      end else begin
         shamt = '0;
      end
   end

   // Same shift on both keeps the ratio, and diff <= sum still holds
   assign sum_trunc  = op_t'(sum_pre >> shamt);
   assign diff_trunc = op_t'(diff_abs >> shamt);

   // Bring down the next numerator bit, subtract if it fits
   assign trial    = {rem, quo[MULT_WIDTH-1]};
   assign fits     = trial >= {1'b0, den};
   assign rem_next = fits ? op_t'(trial - {1'b0, den}) : op_t'(trial);
   assign quo_next = {quo[MULT_WIDTH-2:0], fits};

   // Zero denominator means early and late were both zero
   assign quo_final = (den == '0) ? '0 : quo_next;

   // Undo the fixed-point scale of K
   assign mag = dphi_t'(quo_final >> SCALE_SHIFT);

   assign last_step = (state == DIVIDE) && (step == step_t'(DIV_STEPS-1));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state                 <= IDLE;
         step                  <= '0;
         busy_q                <= 1'b0;
         result_tag            <= '0;
         delta_phase_increment <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (index_valid) begin
                  state <= LOAD;
               end
            end
            LOAD: begin
               state <= DIVIDE;
               step  <= '0;
            end
            DIVIDE: begin
               step <= step + 1'b1;
               if (last_step) begin
                  state      <= DONE;
                  result_tag <= tag_q;
                  // Late ahead of early gives a negative correction
                  delta_phase_increment <= neg_q ? -mag : mag;
               end
            end
            DONE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase

         // Held from the cycle after op_valid until the result pulse
         if (op_valid) begin
            busy_q <= 1'b1;
         end else if (state == DONE) begin
            busy_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      // Larger leading-one position sets the common truncation
      if (state == IDLE && index_valid) begin
         max_index <= (sum_index > diff_index) ? sum_index : diff_index;
      end
      if (state == LOAD) begin
         den   <= sum_trunc;
         quo   <= mult_t'(diff_trunc) * mult_t'(DLL_SCALE);
         rem   <= '0;
         neg_q <= diff_neg;
         tag_q <= req_tag;
      end else if (state == DIVIDE) begin
         rem <= rem_next;
         quo <= quo_next;
      end
   end

   // busy covers op_valid itself, before busy_q can follow
   assign busy         = busy_q | op_valid;
   assign result_ready = state == DONE;

   // Detector results only come while no division is running
   a_index_in_idle: assert property (
      @(posedge clk) disable iff (!rst_n)
      index_valid |-> state == IDLE
   );

   // |early - late| <= early + late bounds the ratio by one
   a_quo_bound: assert property (
      @(posedge clk) disable iff (!rst_n)
      last_step |-> quo_final <= mult_t'(DLL_SCALE)
   );

endmodule

/* design/dll_discriminator.sv */
`timescale 1ns/1ps

module dll_discriminator
   import dll_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        start,
   input  channel_id_t tag,
   input  iq_t         iq_early,
   input  iq_t         iq_late,
   output logic        busy,
   output logic        result_ready,
   output channel_id_t result_tag,
   output dphi_t       delta_phase_increment
);

   // Registered request
   op_pre_t     sum_pre;
   op_pre_t     diff_abs;
   logic        diff_neg;
   channel_id_t req_tag;
   logic        op_valid;

   // Leading-one positions
   op_index_t   sum_index;
   op_index_t   diff_index;
   logic        sum_valid;

   dll_operand_prep prep (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .tag      (tag),
      .iq_early (iq_early),
      .iq_late  (iq_late),
      .sum_pre  (sum_pre),
      .diff_abs (diff_abs),
      .diff_neg (diff_neg),
      .req_tag  (req_tag),
      .op_valid (op_valid)
   );

   // Both detectors run side by side on the same strobe
   dll_lead_detect sum_detect (
      .clk           (clk),
      .rst_n         (rst_n),
      .operand       (sum_pre),
      .operand_valid (op_valid),
      .index         (sum_index),
      .index_valid   (sum_valid)
   );

   dll_lead_detect diff_detect (
      .clk           (clk),
      .rst_n         (rst_n),
      .operand       (diff_abs),
      .operand_valid (op_valid),
      .index         (diff_index),
      .index_valid   ()
   );

   // Sum-side strobe paces the core
   dll_ratio_core core (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .sum_pre               (sum_pre),
      .diff_abs              (diff_abs),
      .diff_neg              (diff_neg),
      .req_tag               (req_tag),
      .op_valid              (op_valid),
      .sum_index             (sum_index),
      .diff_index            (diff_index),
      .index_valid           (sum_valid),
      .busy                  (busy),
      .result_ready          (result_ready),
      .result_tag            (result_tag),
      .delta_phase_increment (delta_phase_increment)
   );

endmodule

/* dv/dll_tb.sv */
`timescale 1ns/1ps

module dll_tb
   import dll_pkg::*;
;

   localparam int NUM_DIRECTED = 7;
   localparam int NUM_RANDOM   = 300;
   localparam int NUM_REQ      = NUM_DIRECTED + NUM_RANDOM;
   localparam int MAX_GAP      = 7;
   // Each request takes at most latency + gap + start wait + one spare cycle
   localparam int CYCLE_LIMIT  = NUM_REQ * (DLL_LATENCY + MAX_GAP + 2) + 100;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        start;
   channel_id_t tag;
   iq_t         iq_early;
   iq_t         iq_late;
   logic        busy;
   logic        result_ready;
   channel_id_t result_tag;
   dphi_t       delta_phase_increment;

   logic [31:0] lcg_state = 32'hb0b1aa8c;
   int          cycles = 0;

   // Expected results with the oldest first
   channel_id_t exp_tag_q[$];
   dphi_t       exp_dphi_q[$];

   // Monitor state
   logic        active = 1'b0;
   int          since_start = 0;
   channel_id_t last_tag = '0;
   dphi_t       last_dphi = '0;
   int          done_count = 0;

   dll_discriminator UUT (
      .clk                   (clk),
      .rst_n                 (rst_n),
      .start                 (start),
      .tag                   (tag),
      .iq_early              (iq_early),
      .iq_late               (iq_late),
      .busy                  (busy),
      .result_ready          (result_ready),
      .result_tag            (result_tag),
      .delta_phase_increment (delta_phase_increment)
   );

   always #2 clk = ~clk;

   function logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Position of the highest set bit or zero for a zero value
   function automatic op_index_t lead_index(input op_pre_t v);
      op_index_t idx;
      idx = '0;
      for (int i = 0; i < OP_PRE_WIDTH; i++) begin
         if (v[i]) begin
            idx = op_index_t'(i);
         end
      end
      return idx;
   endfunction

   // Reference discriminator K * (E - L) / (E + L) scaled back down
   function automatic dphi_t model_dphi(input iq_t early, input iq_t late);
      op_pre_t   sum;
      op_pre_t   diff;
      op_index_t top;
      int        shamt;
      op_t       s_t;
      op_t       d_t;
      longint    num;
      longint    q;
      dphi_t     mag;
      sum  = op_pre_t'(early) + op_pre_t'(late);
      diff = (late > early) ? op_pre_t'(late) - op_pre_t'(early)
                            : op_pre_t'(early) - op_pre_t'(late);
      top  = (lead_index(sum) > lead_index(diff)) ? lead_index(sum) : lead_index(diff);
      // Keep OP_WIDTH bits starting at the top set bit
      shamt = (top >= OP_WIDTH - 1) ? int'(top) - (OP_WIDTH - 1) : 0;
      s_t   = op_t'(sum >> shamt);
      d_t   = op_t'(diff >> shamt);
      num   = longint'(d_t) * longint'(DLL_SCALE);
      q     = (s_t == '0) ? 0 : num / longint'(s_t);
      mag   = dphi_t'(q >> SCALE_SHIFT);
      return (late > early) ? -mag : mag;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("mismatch at %0t ns: %s got %0h expected %0h",
                  $time, name, actual, expected);
         $display("TEST FAILED");
         $fatal(1, "check failed");
      end
   endtask

   // One-cycle start strobe with the model result queued alongside
   task automatic send_request(input channel_id_t t, input iq_t e, input iq_t l);
      @(posedge clk);
      start    <= 1'b1;
      tag      <= t;
      iq_early <= e;
      iq_late  <= l;
      exp_tag_q.push_back(t);
      exp_dphi_q.push_back(model_dphi(e, l));
      @(posedge clk);
      start    <= 1'b0;
      // Junk on the inputs outside the start cycle
      tag      <= channel_id_t'(lcg_next() >> 28);
      iq_early <= iq_t'(lcg_next() >> 16);
      iq_late  <= iq_t'(lcg_next() >> 16);
   endtask

   task automatic wait_result();
      do begin
         @(negedge clk);
      end while (result_ready !== 1'b1);
   endtask

   task automatic run_request(input channel_id_t t, input iq_t e, input iq_t l,
                              input int gap);
      send_request(t, e, l);
      wait_result();
      repeat (gap) @(posedge clk);
   endtask

   // Cycle-exact expectations sampled on the falling edge
   always @(negedge clk) begin
      logic exp_ready;
      logic exp_busy;
      if (rst_n) begin
         if (start) begin
            active      = 1'b1;
            since_start = 0;
         end else if (active) begin
            since_start++;
         end
         exp_ready = active && since_start == DLL_LATENCY;
         exp_busy  = active && since_start >= 1 && since_start <= DLL_LATENCY;
         check_value("result_ready", result_ready, exp_ready);
         check_value("busy", busy, exp_busy);
         if (exp_ready) begin
            last_tag  = exp_tag_q.pop_front();
            last_dphi = exp_dphi_q.pop_front();
            done_count++;
            active = 1'b0;
         end
         // Outputs hold between results and stay zero before the first one
         check_value("result_tag", result_tag, last_tag);
         check_value("delta_phase_increment", delta_phase_increment, last_dphi);
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles == CYCLE_LIMIT) begin
         $display("timeout: results stopped arriving after %0d cycles", cycles);
         $display("TEST FAILED");
         $fatal(1, "timeout");
      end
   end

   initial begin
      logic [31:0] r;
      iq_t         e;
      iq_t         l;
      int          gap;
      rst_n    = 1'b0;
      start    = 1'b0;
      tag      = '0;
      iq_early = '0;
      iq_late  = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      // Idle cycles so the monitor sees busy low before any start
      repeat (3) @(posedge clk);

      // Corner cases of zero, equal, both signs and full scale
      run_request(4'h1, 16'd0, 16'd0, 0);
      run_request(4'h2, 16'd1000, 16'd1000, 0);
      run_request(4'h3, 16'd100, 16'd300, 1);
      run_request(4'h4, 16'd300, 16'd100, 0);
      run_request(4'h5, 16'hffff, 16'h0000, 2);
      run_request(4'h6, 16'h0000, 16'hffff, 0);
      run_request(4'h7, 16'hffff, 16'hffff, 0);

      for (int n = 0; n < NUM_RANDOM; n++) begin
         r = lcg_next();
         case (r[31:29])
            // Small magnitudes so the sum fits without truncation
            3'd0, 3'd1, 3'd2: begin
               e = iq_t'(lcg_next() >> 24);
               l = iq_t'(lcg_next() >> 24);
            end
            // Near full range where truncation is always active
            3'd3, 3'd4, 3'd5: begin
               e = 16'hc000 | iq_t'(lcg_next() >> 18);
               l = 16'hc000 | iq_t'(lcg_next() >> 18);
            end
            3'd6: begin
               e = iq_t'(lcg_next() >> 16);
               l = e;
            end
            default: begin
               e = iq_t'(lcg_next() >> 16);
               l = iq_t'(lcg_next() >> 16);
            end
         endcase
         gap = int'(lcg_next() >> 29);
         run_request(channel_id_t'(r >> 24), e, l, gap);
      end

      repeat (3) @(posedge clk);
      if (done_count != NUM_REQ || exp_tag_q.size() != 0) begin
         $display("run ended with %0d of %0d results", done_count, NUM_REQ);
         $display("TEST FAILED");
         $fatal(1, "incomplete run");
      end else begin
         $display("TEST PASSED");
         $finish;
      end
   end

endmodule

/* src.f */
design/dll_pkg.sv
design/dll_operand_prep.sv
design/dll_lead_detect.sv
design/dll_ratio_core.sv
design/dll_discriminator.sv
dv/dll_tb.sv
